/* Bender.yml */
package:
  name: diannao_node

sources:
  # Package and interface first, then stages and the top level
  - source/nfu_pkg.sv
  - source/nfu_prod_if.sv
  - source/nfu_multiply.sv
  - source/nfu_adder_tree.sv
  - source/nfu_sigmoid.sv
  - source/diannao_node.sv

  # Testbench, top module tb_diannao_node
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/tb_diannao_node.sv

/* source/diannao_node.sv */
`timescale 1ns/1ns
`default_nettype none

// DianNao style NFU tile
// fixed four-cycle latency, one item per cycle
module diannao_node #(
    parameter int TN = 4
) (
    input  logic                                clk,
    input  logic                                i_reset,
    // Datapath in
    input  logic                                i_valid,
    input  nfu_pkg::nfu_op_e                    i_op,
    input  logic [TN*nfu_pkg::DATA_W-1:0]       i_inputs,
    input  logic [TN*TN*nfu_pkg::DATA_W-1:0]    i_synapses,
    input  logic [TN*nfu_pkg::DATA_W-1:0]       i_partial,
    // Datapath out
    output logic                                o_valid,
    output nfu_pkg::nfu_op_e                    o_op,
    output logic [TN*nfu_pkg::DATA_W-1:0]       o_result,
    // Sigmoid coefficient port
    input  logic                                i_wb_cyc,
    input  logic                                i_wb_stb,
    input  logic                                i_wb_we,
    input  logic [nfu_pkg::SEG_BITS-1:0]        i_wb_adr,
    input  logic [nfu_pkg::WB_DAT_W-1:0]        i_wb_dat,
    output logic                                o_wb_ack
);
    import nfu_pkg::*;

    // NFU-1 to NFU-2
    nfu_prod_if #(.TN(TN)) prod_link ();

    // NFU-2 to NFU-3
    logic                   sum_valid;
    nfu_op_e                sum_op;
    logic [TN*DATA_W-1:0]   sums;

    // Two cycles: input register, product register
    nfu_multiply #(.TN(TN)) u_multiply (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_valid    (i_valid),
        .i_op       (i_op),
        .i_inputs   (i_inputs),
        .i_synapses (i_synapses),
        .i_partial  (i_partial),
        .o_prod     (prod_link.src)
    );

    // One cycle: adder trees into the stage register
    nfu_adder_tree #(.TN(TN)) u_adder_tree (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_prod     (prod_link.dst),
        .o_valid    (sum_valid),
        .o_op       (sum_op),
        .o_sums     (sums)
    );

    // One cycle: activation or pass-through
    nfu_sigmoid #(.TN(TN)) u_sigmoid (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_valid    (sum_valid),
        .i_op       (sum_op),
        .i_sums     (sums),
        .i_wb_cyc   (i_wb_cyc),
        .i_wb_stb   (i_wb_stb),
        .i_wb_we    (i_wb_we),
        .i_wb_adr   (i_wb_adr),
        .i_wb_dat   (i_wb_dat),
        .o_wb_ack   (o_wb_ack),
        .o_valid    (o_valid),
        .o_op       (o_op),
        .o_result   (o_result)
    );

endmodule

`default_nettype wire

/* source/nfu_adder_tree.sv */
`timescale 1ns/1ns
`default_nettype none

// NFU-2: per-row adder tree plus partial sum, then the NFU-2/NFU-3 register
module nfu_adder_tree #(
    parameter int TN = 4
) (
    input  logic                            clk,
    input  logic                            i_reset,
    nfu_prod_if.dst                         i_prod,
    output logic                            o_valid,
    output nfu_pkg::nfu_op_e                o_op,
    output logic [TN*nfu_pkg::DATA_W-1:0]   o_sums
);
    import nfu_pkg::*;

    // Number of tree nodes per row, leaves included
    localparam int NODES = 2 * TN - 1;

    // Row totals before the stage register
    logic [TN*DATA_W-1:0] row_sum;

    for (genvar r = 0; r < TN; r++) begin : g_row
        // Heap layout
        // node 0 is the root, node k sums nodes 2k+1 and 2k+2
        // leaves sit at TN-1 .. 2TN-2
        logic [DATA_W-1:0] node [NODES];

        // Leaves take this row's products
        for (genvar l = 0; l < TN; l++) begin : g_leaf
            assign node[TN-1+l] = i_prod.products[(r*TN+l)*DATA_W +: DATA_W];
        end

        // Inner adders, balanced for power-of-two TN
        for (genvar n = 0; n < TN - 1; n++) begin : g_node
            assign node[n] = node[2*n+1] + node[2*n+2];
        end

        // Add the partial sum from NBout, wraps at DATA_W
        assign row_sum[r*DATA_W +: DATA_W] =
            node[0] + i_prod.partial[r*DATA_W +: DATA_W];
    end

    // Stage register between arithmetic and activation
    always_ff @(posedge clk) begin
        o_sums <= row_sum;
        if (i_reset) begin
            o_valid <= 1'b0;
            o_op    <= OP_PARTIAL;
        end else begin
            o_valid <= i_prod.valid;
            o_op    <= i_prod.op;
        end
    end

endmodule

`default_nettype wire

/* source/nfu_multiply.sv */
`timescale 1ns/1ns
`default_nettype none

// NFU-1: input registers then all TN x TN products
module nfu_multiply #(
    parameter int TN = 4
) (
    input  logic                                clk,
    input  logic                                i_reset,
    input  logic                                i_valid,
    input  nfu_pkg::nfu_op_e                    i_op,
    input  logic [TN*nfu_pkg::DATA_W-1:0]       i_inputs,
    input  logic [TN*TN*nfu_pkg::DATA_W-1:0]    i_synapses,
    input  logic [TN*nfu_pkg::DATA_W-1:0]       i_partial,
    nfu_prod_if.src                             o_prod
);
    import nfu_pkg::*;

    // NBin and SB style capture registers
    logic [TN*DATA_W-1:0]       nb_in_reg;
    logic [TN*TN*DATA_W-1:0]    sb_reg;
    logic [TN*DATA_W-1:0]       partial_reg;
    logic                       valid_reg;
    nfu_op_e                    op_reg;

    // Products from the captured vectors
    logic [TN*TN*DATA_W-1:0]    products;

    // Input register
    always_ff @(posedge clk) begin
        nb_in_reg   <= i_inputs;
        sb_reg      <= i_synapses;
        partial_reg <= i_partial;
        if (i_reset) begin
            valid_reg <= 1'b0;
            op_reg    <= OP_PARTIAL;
        end else begin
            valid_reg <= i_valid;
            op_reg    <= i_op;
        end
    end

    // One multiplier per synapse
    // row r is output neuron r, column c is input neuron c
    for (genvar r = 0; r < TN; r++) begin : g_row
        for (genvar c = 0; c < TN; c++) begin : g_col
            assign products[(r*TN+c)*DATA_W +: DATA_W] =
                q_mul(nb_in_reg[c*DATA_W +: DATA_W], sb_reg[(r*TN+c)*DATA_W +: DATA_W]);
        end
    end

    // Product register, partial sum rides along
    always_ff @(posedge clk) begin
        o_prod.products <= products;
        o_prod.partial  <= partial_reg;
        if (i_reset) begin
            o_prod.valid <= 1'b0;
            o_prod.op    <= OP_PARTIAL;
        end else begin
            o_prod.valid <= valid_reg;
            o_prod.op    <= op_reg;
        end
    end

endmodule

`default_nettype wire

/* source/nfu_pkg.sv */
`default_nettype none

package nfu_pkg;

    // Word size for neurons, synapses and coefficients
    parameter int DATA_W = 16;

    // Q8.8 fixed point
    parameter int FRAC_BITS = 8;

    // Full-width signed product before truncation
    parameter int PROD_W = 2 * DATA_W;

    // Coefficient word on the Wishbone bus: slope high, offset low
    parameter int WB_DAT_W = 2 * DATA_W;

    // Sigmoid segment index width and segment count
    parameter int SEG_BITS = 4;
    parameter int SEG_N = 1 << SEG_BITS;

    // Result selection at the end of the pipe
    typedef enum logic {
        OP_PARTIAL = 1'b0,  // raw sum, goes back to NBout
        OP_FINAL   = 1'b1   // sum through the sigmoid
    } nfu_op_e;

    // Q8.8 multiply
    // Arithmetic shift by FRAC_BITS, low DATA_W bits kept
    function automatic logic [DATA_W-1:0] q_mul(
        input logic signed [DATA_W-1:0] a,
        input logic signed [DATA_W-1:0] b
    );
        logic signed [PROD_W-1:0] full;
        full = a * b;
        return full[FRAC_BITS +: DATA_W];
    endfunction

endpackage

`default_nettype wire

/* source/nfu_prod_if.sv */
`timescale 1ns/1ns
`default_nettype none

// Stage 1 to stage 2 link
interface nfu_prod_if #(
    parameter int TN = 4
);
    import nfu_pkg::*;

    logic                       valid;
    nfu_op_e                    op;
    // TN x TN truncated products, row-major like the synapse matrix
    logic [TN*TN*DATA_W-1:0]    products;
    // Partial sums kept aligned with their own products
    logic [TN*DATA_W-1:0]       partial;

    // Driven by the multiplier stage
    modport src (output valid, op, products, partial);

    // Read by the adder tree stage
    modport dst (input valid, op, products, partial);

endinterface

`default_nettype wire

/* source/nfu_sigmoid.sv */
`timescale 1ns/1ns
`default_nettype none

// NFU-3: piecewise-linear sigmoid or pass-through
module nfu_sigmoid #(
    parameter int TN = 4
) (
    input  logic                                clk,
    input  logic                                i_reset,
    input  logic                                i_valid,
    input  nfu_pkg::nfu_op_e                    i_op,
    input  logic [TN*nfu_pkg::DATA_W-1:0]       i_sums,
    // Wishbone classic slave, write only
    input  logic                                i_wb_cyc,
    input  logic                                i_wb_stb,
    input  logic                                i_wb_we,
    input  logic [nfu_pkg::SEG_BITS-1:0]        i_wb_adr,
    input  logic [nfu_pkg::WB_DAT_W-1:0]        i_wb_dat,
    output logic                                o_wb_ack,
    output logic                                o_valid,
    output nfu_pkg::nfu_op_e                    o_op,
    output logic [TN*nfu_pkg::DATA_W-1:0]       o_result
);
    import nfu_pkg::*;

    // One slope/offset pair per segment
    logic [WB_DAT_W-1:0] coef_ram [SEG_N];

    // Bus request this cycle
    // the ack term keeps a held stb from counting twice
    logic wb_req;

    // Activated values for all neurons
    logic [TN*DATA_W-1:0] act;

    assign wb_req = i_wb_cyc && i_wb_stb && !o_wb_ack;

    // Coefficient writes
    always_ff @(posedge clk) begin
        if (wb_req && i_wb_we) begin
            coef_ram[i_wb_adr] <= i_wb_dat;
        end
    end

    // Single-cycle ack, reads get one too
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= wb_req;
        end
    end

    for (genvar n = 0; n < TN; n++) begin : g_neuron
        logic [DATA_W-1:0]      x;
        logic [SEG_BITS-1:0]    seg;
        logic [WB_DAT_W-1:0]    coef;
        logic [DATA_W-1:0]      slope;
        logic [DATA_W-1:0]      offset;

        assign x = i_sums[n*DATA_W +: DATA_W];

        // Segment from the top bits, sign included
        assign seg = x[DATA_W-1 -: SEG_BITS];

        // Asynchronous RAM read
        assign coef   = coef_ram[seg];
        assign slope  = coef[WB_DAT_W-1 -: DATA_W];
        assign offset = coef[DATA_W-1:0];

        // slope * x in Q8.8, then offset, wraps
        assign act[n*DATA_W +: DATA_W] = q_mul(slope, x) + offset;
    end

    // Output register
    // partial results skip the activation
    always_ff @(posedge clk) begin
        if (i_op == OP_FINAL) begin
            o_result <= act;
        end else begin
            o_result <= i_sums;
        end
        if (i_reset) begin
            o_valid <= 1'b0;
            o_op    <= OP_PARTIAL;
        end else begin
            o_valid <= i_valid;
            o_op    <= i_op;
        end
    end

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

// Free-running testbench clock
module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD / 2) o_clk = ~o_clk;
        end
    end

endmodule

`default_nettype wire

/* tb/tb_diannao_node.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_diannao_node;
    import nfu_pkg::*;

    localparam int TN          = 4;
    localparam int DRIVE_DELAY = 10;
    localparam int ACK_LIMIT   = 16;
    localparam int DRAIN_LIMIT = 40;

    logic                       clk;
    logic                       i_reset;
    logic                       i_valid;
    nfu_op_e                    i_op;
    logic [TN*DATA_W-1:0]       i_inputs;
    logic [TN*TN*DATA_W-1:0]    i_synapses;
    logic [TN*DATA_W-1:0]       i_partial;
    logic                       o_valid;
    nfu_op_e                    o_op;
    logic [TN*DATA_W-1:0]       o_result;
    logic                       i_wb_cyc;
    logic                       i_wb_stb;
    logic                       i_wb_we;
    logic [SEG_BITS-1:0]        i_wb_adr;
    logic [WB_DAT_W-1:0]        i_wb_dat;
    logic                       o_wb_ack;

    // Mirror of the coefficient RAM as written over the bus
    logic [WB_DAT_W-1:0]        coef_table [SEG_N];

    // Expected results in issue order
    logic [TN*DATA_W-1:0]       exp_res_q [$];
    nfu_op_e                    exp_op_q [$];

    // Front of the queue for the output seen at the last falling edge
    logic [TN*DATA_W-1:0]       exp_result;
    nfu_op_e                    exp_op;
    logic                       exp_present;

    int value_errors;
    int other_errors;
    int items_checked;

    tb_clock #(.PERIOD(100)) i_tb_clock (.o_clk(clk));

    diannao_node #(.TN(TN)) i_diannao_node (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_valid    (i_valid),
        .i_op       (i_op),
        .i_inputs   (i_inputs),
        .i_synapses (i_synapses),
        .i_partial  (i_partial),
        .o_valid    (o_valid),
        .o_op       (o_op),
        .o_result   (o_result),
        .i_wb_cyc   (i_wb_cyc),
        .i_wb_stb   (i_wb_stb),
        .i_wb_we    (i_wb_we),
        .i_wb_adr   (i_wb_adr),
        .i_wb_dat   (i_wb_dat),
        .o_wb_ack   (o_wb_ack)
    );

    // Q8.8 product by arithmetic shift of the full signed product
    function automatic logic [DATA_W-1:0] fixed_mul(input logic [DATA_W-1:0] a,
                                                    input logic [DATA_W-1:0] b);
        logic signed [2*DATA_W-1:0] full;
        logic signed [2*DATA_W-1:0] shifted;
        full    = $signed(a) * $signed(b);
        shifted = full >>> FRAC_BITS;
        return shifted[DATA_W-1:0];
    endfunction

    // Reference model for one item
    function automatic logic [TN*DATA_W-1:0] model_output(
        input nfu_op_e                  op,
        input logic [TN*DATA_W-1:0]     inputs,
        input logic [TN*TN*DATA_W-1:0]  syn,
        input logic [TN*DATA_W-1:0]     partial
    );
        logic [TN*DATA_W-1:0]   res;
        logic [DATA_W-1:0]      acc;
        logic [WB_DAT_W-1:0]    coef;
        for (int r = 0; r < TN; r++) begin
            acc = partial[r*DATA_W +: DATA_W];
            for (int c = 0; c < TN; c++) begin
                acc = acc + fixed_mul(inputs[c*DATA_W +: DATA_W],
                                      syn[(r*TN+c)*DATA_W +: DATA_W]);
            end
            // Segment is the top SEG_BITS of the sum
            coef = coef_table[acc[DATA_W-1 -: SEG_BITS]];
            if (op == OP_FINAL) begin
                acc = fixed_mul(coef[WB_DAT_W-1 -: DATA_W], acc) + coef[DATA_W-1:0];
            end
            res[r*DATA_W +: DATA_W] = acc;
        end
        return res;
    endfunction

    // Value within about +-4.0 in Q8.8
    function automatic logic [DATA_W-1:0] small_word();
        return DATA_W'($urandom_range(0, 2047)) - DATA_W'(1024);
    endfunction

    // Move to the drive point of the next cycle
    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic drive_item(input nfu_op_e op,
                              input logic [TN*DATA_W-1:0] inputs,
                              input logic [TN*TN*DATA_W-1:0] syn,
                              input logic [TN*DATA_W-1:0] partial);
        i_valid    = 1'b1;
        i_op       = op;
        i_inputs   = inputs;
        i_synapses = syn;
        i_partial  = partial;
        exp_res_q.push_back(model_output(op, inputs, syn, partial));
        exp_op_q.push_back(op);
        step();
    endtask

    // Small random vectors with partial sums over the full range
    task automatic random_item(input nfu_op_e op);
        logic [TN*DATA_W-1:0]       inputs;
        logic [TN*TN*DATA_W-1:0]    syn;
        logic [TN*DATA_W-1:0]       partial;
        for (int k = 0; k < TN; k++) begin
            inputs[k*DATA_W +: DATA_W]  = small_word();
            partial[k*DATA_W +: DATA_W] = DATA_W'($urandom);
        end
        for (int k = 0; k < TN*TN; k++) begin
            syn[k*DATA_W +: DATA_W] = small_word();
        end
        drive_item(op, inputs, syn, partial);
    endtask

    task automatic idle_cycle();
        i_valid = 1'b0;
        step();
    endtask

    // One Wishbone classic cycle with stb dropped on ack
    task automatic wb_cycle(input logic we, input logic [SEG_BITS-1:0] adr,
                            input logic [WB_DAT_W-1:0] dat);
        int waited;
        waited   = 0;
        i_wb_cyc = 1'b1;
        i_wb_stb = 1'b1;
        i_wb_we  = we;
        i_wb_adr = adr;
        i_wb_dat = dat;
        if (we) begin
            coef_table[adr] = dat;
        end
        do begin
            step();
            waited++;
        end while (!o_wb_ack && waited < ACK_LIMIT);
        if (!o_wb_ack) begin
            other_errors++;
            $display("Wishbone cycle to segment %0d was never acknowledged", adr);
        end
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
        // Bus stays idle for the cycle in which the ack ends
        step();
    endtask

    // Wait until every issued item has come out
    task automatic drain();
        int waited;
        waited  = 0;
        i_valid = 1'b0;
        while (exp_res_q.size() != 0 && waited < DRAIN_LIMIT) begin
            step();
            waited++;
        end
        if (exp_res_q.size() != 0) begin
            other_errors++;
            $display("Timed out with %0d results still missing", exp_res_q.size());
        end
        // Let the check on the last result fire
        repeat (2) step();
    endtask

    // Load the expectation for the output register seen this cycle
    always @(negedge clk) begin
        exp_present = 1'b0;
        if (o_valid === 1'b1 && exp_res_q.size() != 0) begin
            exp_result  = exp_res_q.pop_front();
            exp_op      = exp_op_q.pop_front();
            exp_present = 1'b1;
            items_checked++;
        end
    end

    // Outputs stay quiet during reset and on the cycle after it
    a_reset_quiet: assert property (@(posedge clk) i_reset |=> (!o_valid && !o_wb_ack))
        else begin
            value_errors++;
            $display("[ERROR] %0t o_valid/o_wb_ack expected 0/0 actual %b/%b",
                     $time, $sampled(o_valid), $sampled(o_wb_ack));
        end

    // Fixed four-cycle latency
    a_latency: assert property (@(posedge clk) disable iff (i_reset)
                                o_valid == $past(i_valid, 4))
        else begin
            value_errors++;
            $display("[ERROR] %0t o_valid expected %b actual %b",
                     $time, !$sampled(o_valid), $sampled(o_valid));
        end

    a_expected: assert property (@(posedge clk) disable iff (i_reset) o_valid |-> exp_present)
        else begin
            other_errors++;
            $display("An output appeared at %0t with no item waiting for it", $time);
        end

    a_result: assert property (@(posedge clk) disable iff (i_reset)
                               (o_valid && exp_present) |-> o_result == exp_result)
        else begin
            value_errors++;
            $display("[ERROR] %0t o_result expected %h actual %h",
                     $time, exp_result, $sampled(o_result));
        end

    a_op: assert property (@(posedge clk) disable iff (i_reset)
                           (o_valid && exp_present) |-> o_op == exp_op)
        else begin
            value_errors++;
            $display("[ERROR] %0t o_op expected %b actual %b",
                     $time, exp_op, $sampled(o_op));
        end

    // Ack one cycle after a new request and for one cycle only
    a_ack_rise: assert property (@(posedge clk) disable iff (i_reset)
                                 (i_wb_cyc && i_wb_stb && !o_wb_ack) |=> o_wb_ack)
        else begin
            value_errors++;
            $display("[ERROR] %0t o_wb_ack expected 1 actual 0", $time);
        end

    a_ack_pulse: assert property (@(posedge clk) disable iff (i_reset) o_wb_ack |=> !o_wb_ack)
        else begin
            value_errors++;
            $display("[ERROR] %0t o_wb_ack expected 0 actual 1", $time);
        end

    initial begin
        logic [TN*DATA_W-1:0]       inputs;
        logic [TN*TN*DATA_W-1:0]    syn;
        logic [TN*DATA_W-1:0]       partial;
        void'($urandom(32'h1bc7_dd30));
        value_errors  = 0;
        other_errors  = 0;
        items_checked = 0;
        exp_present   = 1'b0;
        i_reset       = 1'b1;
        i_valid       = 1'b0;
        i_op          = OP_PARTIAL;
        i_inputs      = '0;
        i_synapses    = '0;
        i_partial     = '0;
        i_wb_cyc      = 1'b0;
        i_wb_stb      = 1'b0;
        i_wb_we       = 1'b0;
        i_wb_adr      = '0;
        i_wb_dat      = '0;
        repeat (8) @(posedge clk);
        #DRIVE_DELAY;
        i_reset = 1'b0;
        repeat (3) idle_cycle();

        // Full coefficient table with slopes within +-2.0
        for (int s = 0; s < SEG_N; s++) begin
            wb_cycle(1'b1, SEG_BITS'(s),
                     {DATA_W'($urandom_range(0, 1023)) - DATA_W'(512), small_word()});
        end
        // A read must not disturb the table
        wb_cycle(1'b0, SEG_BITS'(5), 32'hdead_beef);

        // Dot products that wrap upwards and downwards
        inputs  = {TN{16'h0800}};
        syn     = {TN*TN{16'h0700}};
        drive_item(OP_PARTIAL, inputs, syn, {16'h7000, 16'h8123, 16'h0000, 16'hffff});
        inputs  = {TN{16'hf800}};
        drive_item(OP_PARTIAL, inputs, syn, {16'h8000, 16'h7fff, 16'h1234, 16'h0001});
        for (int k = 0; k < 8; k++) begin
            random_item(OP_PARTIAL);
        end

        // One sweep per segment with sums equal to the partial vector
        for (int s = 0; s < SEG_N; s++) begin
            for (int k = 0; k < TN; k++) begin
                partial[k*DATA_W +: DATA_W] = {SEG_BITS'(s + k), 12'($urandom)};
            end
            drive_item(OP_FINAL, '0, {TN*TN{16'h0100}}, partial);
        end

        // Back-to-back mix then random gaps
        for (int k = 0; k < 24; k++) begin
            random_item(nfu_op_e'($urandom_range(0, 1)));
        end
        for (int k = 0; k < 30; k++) begin
            if ($urandom_range(0, 2) == 0) begin
                idle_cycle();
            end else begin
                random_item(nfu_op_e'($urandom_range(0, 1)));
            end
        end
        drain();

        // New coefficients for segment 3 while idle
        wb_cycle(1'b1, SEG_BITS'(3), {16'h0180, 16'hff40});
        for (int k = 0; k < 4; k++) begin
            for (int n = 0; n < TN; n++) begin
                partial[n*DATA_W +: DATA_W] = {SEG_BITS'(3), 12'($urandom)};
            end
            drive_item(OP_FINAL, '0, '0, partial);
        end
        drain();

        $display("Summary: %0d results checked, %0d value errors, %0d other errors",
                 items_checked, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
source/nfu_pkg.sv
source/nfu_prod_if.sv
source/nfu_multiply.sv
source/nfu_adder_tree.sv
source/nfu_sigmoid.sv
source/diannao_node.sv
tb/tb_clock.sv
tb/tb_diannao_node.sv
